//--- source/dcache_defines.svh
// memory depth, memory latency and 1-bit level macros for the data-side access unit

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

//------------------------------
// burst memory
//------------------------------
`define DCACHE_MEM_WORDS   256   // dwords, address wraps at 4x this in bytes
`define DCACHE_MEM_LATENCY 3     // cycles from burst do to burst done

//------------------------------
// levels
//------------------------------
`define TRUE  1'b1
`define FALSE 1'b0

`endif

//--- source/dcache_pkg.sv
// request, burst and snoop packed structs of the data-side access unit

package dcache_pkg;

   //------------------------------
   // requester side
   //------------------------------

   // read, 1 to 8 bytes at any byte address
   typedef struct packed {
      logic [31:0] address;
      logic [3:0]  length;        // bytes, 1..8
   } dcache_rd_req_t;

   // posted write, 1 to 4 bytes
   typedef struct packed {
      logic [31:0] address;
      logic [2:0]  length;        // bytes, 1..4
      logic [31:0] data;          // lsb first
   } dcache_wr_req_t;

   //------------------------------
   // memory side
   //------------------------------

   typedef struct packed {
      logic [31:0] address;       // dword aligned
      logic [1:0]  dword_length;  // dwords - 1
      logic [3:0]  byte_length;
   } rd_burst_req_t;

   typedef struct packed {
      logic [31:0] address;       // dword aligned
      logic [1:0]  dword_length;  // 0 or 1
      logic [3:0]  byteenable_0;  // first dword
      logic [3:0]  byteenable_1;  // second dword
      logic [55:0] data;          // write data moved up by the byte offset
   } wr_burst_req_t;

   // write notice toward the instruction cache
   typedef struct packed {
      logic        valid;
      logic [31:0] address;
   } icache_snoop_t;

endpackage

//--- source/dcache_read_align.sv
// read burst sizing and byte extraction from the returned dwords

`timescale 1ns/10ps

module dcache_read_align (
   input  dcache_pkg::dcache_rd_req_t req,      // held by requester
   input  logic [95:0]                rd_data,  // lowest address in low dword
   output dcache_pkg::rd_burst_req_t  burst,
   output logic [63:0]                read_data
);

   import dcache_pkg::*;

   //------------------------------
   // burst sizing
   //------------------------------

   logic [1:0]  offset;      // byte offset in first dword
   logic [3:0]  last_byte;   // offset of last requested byte
   logic [95:0] shifted;     // first requested byte at bit 0
   logic [63:0] keep_mask;   // ones over the requested bytes

   assign offset    = req.address[1:0];
   assign last_byte = {2'b00, offset} + req.length - 4'd1;   // max 3 + 8 - 1

   // dword count is last_byte / 4 + 1, field holds count - 1
   assign burst.address      = {req.address[31:2], 2'b00};
   assign burst.dword_length = last_byte[3:2];
   assign burst.byte_length  = req.length;

   //------------------------------
   // byte extraction
   //------------------------------

   assign shifted = rd_data >> {offset, 3'b000};   // 0, 8, 16 or 24 bits

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         // bytes past the length read as zero
         keep_mask[8*i +: 8] = (4'(i) < req.length) ? 8'hff : 8'h00;
      end
   end

   assign read_data = shifted[63:0] & keep_mask;

   //------------------------------
   // checks
   //------------------------------

   // requester contract, an all-zero request is an idle bus
   always_comb begin
      a_rd_length: assert final (req == '0 ||
                                 (req.length >= 4'd1 && req.length <= 4'd8))
         else $error("dcache_read_align: read length %0d out of range", req.length);
   end

endmodule

//--- source/dcache_write_align.sv
// write byte enables and data placement for a 1 or 2 dword burst

`timescale 1ns/10ps

module dcache_write_align (
   input  dcache_pkg::dcache_wr_req_t req,    // held by requester
   output dcache_pkg::wr_burst_req_t  burst
);

   import dcache_pkg::*;

   //------------------------------
   // byte mask
   //------------------------------

   logic [1:0] offset;       // byte offset in first dword
   logic [7:0] len_ones;     // length ones from the lsb
   logic [7:0] byte_mask;    // spans two dwords

   assign offset = req.address[1:0];

   // 9 bits hold 1 << length for any 3-bit length
   assign len_ones  = 8'((9'd1 << req.length) - 9'd1);
   assign byte_mask = len_ones << offset;

   //------------------------------
   // burst fields
   //------------------------------

   assign burst.address      = {req.address[31:2], 2'b00};
   assign burst.byteenable_0 = byte_mask[3:0];
   assign burst.byteenable_1 = byte_mask[7:4];

   // second dword only when the write crosses the boundary
   assign burst.dword_length = (byte_mask[7:4] != 4'b0000) ? 2'd1 : 2'd0;

   // same shift as the mask into 32 + 24 bits
   assign burst.data = 56'(req.data) << {offset, 3'b000};

   //------------------------------
   // checks
   //------------------------------

   // an all-zero request is an idle bus
   always_comb begin
      a_wr_length: assert final (req == '0 ||
                                 (req.length >= 3'd1 && req.length <= 3'd4))
         else $error("dcache_write_align: write length %0d out of range", req.length);
   end

endmodule

//--- source/dcache_ctrl.sv
// idle / read burst / write through FSM with acknowledges, burst strobes and snoop

`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_ctrl (
   input  logic                      clk,
   input  logic                      rst_n,
   // requester strobes
   input  logic                      read_do,
   input  logic                      write_do,
   input  logic                      invd_do,
   input  logic                      wbinvd_do,
   // memory completions
   input  logic                      rd_burst_done,
   input  logic                      wr_burst_done,
   input  logic [31:0]               write_addr,   // for the snoop
   // acknowledges
   output logic                      read_done,
   output logic                      write_done,
   output logic                      invd_done,
   output logic                      wbinvd_done,
   // burst strobes
   output logic                      rd_burst_do,
   output logic                      wr_burst_do,
   output dcache_pkg::icache_snoop_t snoop,
   output logic                      busy
);

   import dcache_pkg::*;

   //------------------------------
   // state
   //------------------------------

   typedef enum logic [1:0] {
      ST_IDLE          = 2'd0,
      ST_READ_BURST    = 2'd1,
      ST_WRITE_THROUGH = 2'd2
   } state_t;

   state_t state;

   logic idle;
   logic take_write;    // write wins over everything
   logic take_read;
   logic take_invd;
   logic take_wbinvd;   // lowest priority

   assign idle = (state == ST_IDLE);

   // arbitration only in idle
   assign take_write  = idle && write_do;
   assign take_read   = idle && !write_do && read_do;
   assign take_invd   = idle && !write_do && !read_do && invd_do;
   assign take_wbinvd = idle && !write_do && !read_do && !invd_do && wbinvd_do;

   //------------------------------
   // strobes and acknowledges
   //------------------------------

   // posted write acked with its burst in the same cycle
   assign write_done  = !rst_n ? `FALSE : take_write;
   assign wr_burst_do = !rst_n ? `FALSE : take_write;

   assign rd_burst_do = !rst_n ? `FALSE : take_read;
   assign read_done   = !rst_n ? `FALSE : (state == ST_READ_BURST) && rd_burst_done;

   // no lines held so nothing to flush
   assign invd_done   = !rst_n ? `FALSE : take_invd;
   assign wbinvd_done = !rst_n ? `FALSE : take_wbinvd;

   assign snoop.valid   = !rst_n ? `FALSE : take_write;   // icache drops the line
   assign snoop.address = write_addr;

   assign busy = !idle;

   //------------------------------
   // next state
   //------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (take_write) begin
                  state <= ST_WRITE_THROUGH;
               end else if (take_read) begin
                  state <= ST_READ_BURST;
               end
            end
            ST_READ_BURST: begin
               if (rd_burst_done) state <= ST_IDLE;   // data handed over
            end
            ST_WRITE_THROUGH: begin
               if (wr_burst_done) state <= ST_IDLE;   // memory updated
            end
            default: state <= ST_IDLE;   // unused encoding
         endcase
      end
   end

   //------------------------------
   // checks
   //------------------------------

   // memory read data only lands while a read burst is open
   a_rd_done_state: assert property (@(posedge clk) disable iff (!rst_n)
      rd_burst_done |-> (state == ST_READ_BURST));

   // write completion only ends a write-through stretch
   a_wr_done_state: assert property (@(posedge clk) disable iff (!rst_n)
      wr_burst_done |-> (state == ST_WRITE_THROUGH));

endmodule

//--- source/burst_mem.sv
// dword burst memory model with fixed latency, byte-enabled writes and 3-dword reads

`timescale 1ns/10ps

`include "dcache_defines.svh"

module burst_mem (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      rd_do,
   input  dcache_pkg::rd_burst_req_t rd_req,
   input  logic                      wr_do,
   input  dcache_pkg::wr_burst_req_t wr_req,
   output logic                      rd_done,
   output logic                      wr_done,
   output logic [95:0]               rd_data    // valid with rd_done
);

   import dcache_pkg::*;

   localparam int AW = $clog2(`DCACHE_MEM_WORDS);        // dword index bits
   localparam int CW = $clog2(`DCACHE_MEM_LATENCY + 1);  // counter bits

   logic [31:0]   mem [`DCACHE_MEM_WORDS];
   logic [CW-1:0] cnt;        // 0 when no burst is pending
   logic          is_write;   // kind of the pending burst
   logic          done;
   rd_burst_req_t rd_q;       // captured on rd_do
   wr_burst_req_t wr_q;       // captured on wr_do
   logic [AW-1:0] rd_idx;
   logic [AW-1:0] wr_idx;
   logic [AW-1:0] wr_idx_nxt; // second dword, wraps
   logic [63:0]   wr_wide;    // write data padded to two dwords

   //------------------------------
   // latency counter
   //------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt      <= '0;
         is_write <= `FALSE;
      end else if (rd_do || wr_do) begin
         cnt      <= CW'(`DCACHE_MEM_LATENCY);
         is_write <= wr_do;
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign done    = (cnt == CW'(1));   // latency cycles after the do
   assign rd_done = done && !is_write;
   assign wr_done = done && is_write;

   always_ff @(posedge clk) begin
      if (rd_do) rd_q <= rd_req;
      if (wr_do) wr_q <= wr_req;
   end

   //------------------------------
   // storage
   //------------------------------

   assign rd_idx     = rd_q.address[AW+1:2];
   assign wr_idx     = wr_q.address[AW+1:2];
   assign wr_idx_nxt = wr_idx + 1'b1;
   assign wr_wide    = {8'h00, wr_q.data};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int w = 0; w < `DCACHE_MEM_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else if (wr_done) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_q.byteenable_0[b]) mem[wr_idx][8*b +: 8] <= wr_wide[8*b +: 8];
            if (wr_q.dword_length != 2'd0 && wr_q.byteenable_1[b]) begin
               mem[wr_idx_nxt][8*b +: 8] <= wr_wide[32 + 8*b +: 8];
            end
         end
      end
   end

   // read gather, words past the count are zero
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         rd_data[32*i +: 32] = (i <= int'(rd_q.dword_length)) ? mem[rd_idx + AW'(i)] : 32'h0;
      end
   end

   // controller issues only from idle, so bursts never overlap
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      (cnt != '0) |-> !(rd_do || wr_do));

endmodule

//--- source/dcache_top.sv
// data-side access unit top, controller with read/write aligners and burst memory

`timescale 1ns/10ps

module dcache_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       read_do,
   input  dcache_pkg::dcache_rd_req_t read_req,
   output logic                       read_done,
   output logic [63:0]                read_data,
   input  logic                       write_do,
   input  dcache_pkg::dcache_wr_req_t write_req,
   output logic                       write_done,
   input  logic                       invd_do,
   output logic                       invd_done,
   input  logic                       wbinvd_do,
   output logic                       wbinvd_done,
   output dcache_pkg::icache_snoop_t  snoop,
   output logic                       busy
);

   import dcache_pkg::*;

   rd_burst_req_t rd_burst;
   wr_burst_req_t wr_burst;
   logic          rd_burst_do;
   logic          rd_burst_done;
   logic          wr_burst_do;
   logic          wr_burst_done;
   logic [95:0]   mem_rd_data;   // raw dwords from memory

   dcache_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n),
      .read_do(read_do), .write_do(write_do),
      .invd_do(invd_do), .wbinvd_do(wbinvd_do),
      .rd_burst_done(rd_burst_done), .wr_burst_done(wr_burst_done),
      .write_addr(write_req.address),
      .read_done(read_done), .write_done(write_done),
      .invd_done(invd_done), .wbinvd_done(wbinvd_done),
      .rd_burst_do(rd_burst_do), .wr_burst_do(wr_burst_do),
      .snoop(snoop), .busy(busy)
   );

   dcache_read_align u_read_align (
      .req(read_req), .rd_data(mem_rd_data), .burst(rd_burst), .read_data(read_data)
   );

   dcache_write_align u_write_align (.req(write_req), .burst(wr_burst));

   burst_mem u_mem (
      .clk(clk), .rst_n(rst_n),
      .rd_do(rd_burst_do), .rd_req(rd_burst), .wr_do(wr_burst_do), .wr_req(wr_burst),
      .rd_done(rd_burst_done), .wr_done(wr_burst_done), .rd_data(mem_rd_data)
   );

endmodule

//--- verif/dcache_tb.sv
// testbench for the data-side access unit with clock, reset, random requests, shadow memory, checks

`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_tb;

   import dcache_pkg::*;

   localparam int LAT       = `DCACHE_MEM_LATENCY;
   localparam int MEM_BYTES = `DCACHE_MEM_WORDS * 4;   // byte address wraps here
   localparam int NUM_OPS   = 300;
   localparam int TIMEOUT   = NUM_OPS * (LAT + 4) + 100;

   logic           clk = 1'b0;
   logic           rst_n;
   logic           read_do;
   dcache_rd_req_t read_req;
   logic           read_done;
   logic [63:0]    read_data;
   logic           write_do;
   dcache_wr_req_t write_req;
   logic           write_done;
   logic           invd_do;
   logic           invd_done;
   logic           wbinvd_do;
   logic           wbinvd_done;
   icache_snoop_t  snoop;
   logic           busy;

   logic [7:0]  shadow [MEM_BYTES];   // what memory should hold
   logic [63:0] exp_read_data;
   logic [5:0]  out_vec;              // every output that must be quiet in reset
   int unsigned cycle_count = 0;
   int unsigned busy_cycles;          // length of the running busy stretch
   int unsigned rd_age;               // cycles since the read was taken or 0
   logic        rst_n_q = 1'b0;

   always #10 clk = ~clk;   // 20 ns period

   dcache_top UUT (
      .clk(clk), .rst_n(rst_n),
      .read_do(read_do), .read_req(read_req), .read_done(read_done), .read_data(read_data),
      .write_do(write_do), .write_req(write_req), .write_done(write_done),
      .invd_do(invd_do), .invd_done(invd_done),
      .wbinvd_do(wbinvd_do), .wbinvd_done(wbinvd_done),
      .snoop(snoop), .busy(busy)
   );

   //------------------------------
   // failure reporting
   //------------------------------

   task automatic stop_with_failure();
      $display("Verification failed");
      $fatal(1, "run stopped at the first failing check");
   endtask

   task automatic report_mismatch(input string test, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
      stop_with_failure();
   endtask

   //------------------------------
   // reference model
   //------------------------------

   function automatic int byte_index(input logic [31:0] addr, input int i);
      return int'((addr + 32'(i)) % 32'(MEM_BYTES));   // wraps like the memory
   endfunction

   // posted write lands in the shadow at its acknowledge
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_BYTES; i++) shadow[i] <= 8'h00;
      end else if (write_done) begin
         for (int i = 0; i < 4; i++) begin
            if (i < int'(write_req.length)) begin
               shadow[byte_index(write_req.address, i)] <= write_req.data[8*i +: 8];
            end
         end
      end
   end

   always_comb begin
      exp_read_data = '0;   // bytes past the length stay zero
      for (int i = 0; i < 8; i++) begin
         if (i < int'(read_req.length)) begin
            exp_read_data[8*i +: 8] = shadow[byte_index(read_req.address, i)];
         end
      end
   end

   assign out_vec = {read_done, write_done, invd_done, wbinvd_done, snoop.valid, busy};

   //------------------------------
   // cycle bookkeeping
   //------------------------------

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      rst_n_q     <= rst_n;
      busy_cycles <= (!rst_n || !busy) ? 0 : busy_cycles + 1;
      if (!rst_n || read_done) rd_age <= 0;
      else if (rd_age != 0) rd_age <= rd_age + 1;
      else if (read_do && !write_do && !busy) rd_age <= 1;   // read wins this cycle
      if (cycle_count >= TIMEOUT) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         stop_with_failure();
      end
   end

   //------------------------------
   // checks
   //------------------------------

   a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      read_done |-> read_data == exp_read_data)
      else report_mismatch("read data", $sampled(exp_read_data), $sampled(read_data));

   a_write_ack: assert property (@(posedge clk) disable iff (!rst_n)
      (write_do && !busy) |-> write_done)
      else report_mismatch("write ack", 64'(1), 64'($sampled(write_done)));

   a_snoop_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (write_do && !busy) |-> snoop.valid)
      else report_mismatch("snoop valid", 64'(1), 64'($sampled(snoop.valid)));

   a_snoop_addr: assert property (@(posedge clk) disable iff (!rst_n)
      write_done |-> snoop.address == write_req.address)
      else report_mismatch("snoop address", 64'($sampled(write_req.address)),
                           64'($sampled(snoop.address)));

   a_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
      write_done |=> busy)
      else report_mismatch("busy after write", 64'(1), 64'($sampled(busy)));

   // every busy stretch of a write or a read lasts the memory latency
   a_busy_max: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> busy_cycles < LAT)
      else report_mismatch("busy length", 64'(LAT), 64'($sampled(busy_cycles) + 1));

   a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
      (!busy && busy_cycles != 0) |-> busy_cycles == LAT)
      else report_mismatch("busy length", 64'(LAT), 64'($sampled(busy_cycles)));

   a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
      read_done |-> rd_age == LAT)
      else report_mismatch("read latency", 64'(LAT), 64'($sampled(rd_age)));

   a_read_due: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_age == LAT) |-> read_done)
      else report_mismatch("read done due", 64'(1), 64'($sampled(read_done)));

   a_invd_ack: assert property (@(posedge clk) disable iff (!rst_n)
      (invd_do && !write_do && !read_do && !busy) |-> invd_done)
      else report_mismatch("invd ack", 64'(1), 64'($sampled(invd_done)));

   a_wbinvd_ack: assert property (@(posedge clk) disable iff (!rst_n)
      (wbinvd_do && !invd_do && !write_do && !read_do && !busy) |-> wbinvd_done)
      else report_mismatch("wbinvd ack", 64'(1), 64'($sampled(wbinvd_done)));

   a_inv_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (invd_done || wbinvd_done) |-> (!busy && !write_done))
      else report_mismatch("invalidate while busy", 64'(0),
                           64'({$sampled(busy), $sampled(write_done)}));

   // state is still unknown before the first edge
   a_reset_quiet: assert property (@(posedge clk)
      ((!rst_n && cycle_count != 0) || (rst_n && !rst_n_q)) |-> out_vec == '0)
      else report_mismatch("reset state", 64'(0), 64'($sampled(out_vec)));

   //------------------------------
   // stimulus
   //------------------------------

   task automatic release_strobes();
      @(negedge clk);
      read_do   = 1'b0;   // requester drops the do after its done
      write_do  = 1'b0;
      invd_do   = 1'b0;
      wbinvd_do = 1'b0;
   endtask

   task automatic write_bytes(input logic [31:0] addr, input logic [2:0] len,
                              input logic [31:0] data);
      release_strobes();
      write_req.address = addr;
      write_req.length  = len;
      write_req.data    = data;
      write_do          = 1'b1;
      do @(posedge clk); while (!write_done);   // held through back-pressure
   endtask

   task automatic read_bytes(input logic [31:0] addr, input logic [3:0] len);
      release_strobes();
      read_req.address = addr;
      read_req.length  = len;
      read_do          = 1'b1;
      do @(posedge clk); while (!read_done);
   endtask

   task automatic invalidate(input logic writeback, input logic with_write);
      release_strobes();
      if (writeback) begin
         wbinvd_do = 1'b1;
      end else begin
         invd_do = 1'b1;
      end
      if (with_write) begin
         // flush waits out the write that wins the idle cycle
         write_req.address = pick_address();
         write_req.length  = 3'($urandom % 4 + 1);
         write_req.data    = $urandom;
         write_do          = 1'b1;
         do @(posedge clk); while (!write_done);
         @(negedge clk);
         write_do = 1'b0;   // dropped after its own done
      end
      if (writeback) begin
         do @(posedge clk); while (!wbinvd_done);
      end else begin
         do @(posedge clk); while (!invd_done);
      end
   endtask

   // small window so reads see earlier writes plus the wrap point now and then
   function automatic logic [31:0] pick_address();
      logic [31:0] base;
      base = ($urandom % 8 == 0) ? 32'(MEM_BYTES - 8) + ($urandom % 8) : $urandom % 64;
      return base + 32'(MEM_BYTES) * ($urandom % 4);   // high bits alias
   endfunction

   initial begin
      int unsigned pick;
      void'($urandom(63));
      rst_n     = 1'b0;
      read_do   = 1'b0;
      write_do  = 1'b0;
      invd_do   = 1'b0;
      wbinvd_do = 1'b0;
      read_req  = '0;
      write_req = '0;
      repeat (4) @(negedge clk);
      read_do   = 1'b1;   // raised in reset and left unanswered
      write_do  = 1'b1;
      invd_do   = 1'b1;
      wbinvd_do = 1'b1;
      repeat (5) @(negedge clk);
      release_strobes();
      rst_n = 1'b1;
      for (int n = 0; n < NUM_OPS; n++) begin
         pick = $urandom % 20;
         if ($urandom % 4 == 0) release_strobes();   // occasional idle gap
         if (pick < 9) write_bytes(pick_address(), 3'($urandom % 4 + 1), $urandom);
         else if (pick < 18) read_bytes(pick_address(), 4'($urandom % 8 + 1));
         else invalidate(pick == 19, $urandom % 2 == 0);
      end
      release_strobes();
      while (busy) @(negedge clk);   // last posted write drains
      @(negedge clk);
      $display("Verification passed");
      $finish;
   end

endmodule

//--- dcache_top.f
+incdir+source
source/dcache_pkg.sv
source/dcache_read_align.sv
source/dcache_write_align.sv
source/dcache_ctrl.sv
source/burst_mem.sv
source/dcache_top.sv
verif/dcache_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the data-side access unit

VERILATOR ?= verilator
FILELIST  ?= dcache_top.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Verification passed
VFLAGS    ?= --assert -Wno-fatal
LINTFLAGS ?= -Wall
SIM_BIN    = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
